/* cmpxchg_pkg.sv */
`default_nettype none

// shared types and constants for the compare-and-exchange slice.
package cmpxchg_pkg;

    // architectural register width.
    localparam int data_width = 32;

    // width of the status-flag register.
    localparam int num_flags = 6;

    // bit positions inside the flags vector.
    // the order follows the low eflags bits, without the reserved holes.
    localparam int flag_cf = 0;
    localparam int flag_pf = 1;
    localparam int flag_af = 2;
    localparam int flag_zf = 3;
    localparam int flag_sf = 4;
    localparam int flag_of = 5;

    // register-to-register operations.
    typedef enum logic [2:0] {
        op_nop      = 3'd0,
        op_cmpxchg  = 3'd1,
        op_cmp      = 3'd2,
        op_mov      = 3'd3,
        op_load_imm = 3'd4
    } op_e;

    // operand width of an operation.
    // code 3 is unused and treated as a full 32-bit access.
    typedef enum logic [1:0] {
        size_8  = 2'd0,
        size_16 = 2'd1,
        size_32 = 2'd2
    } size_e;

endpackage

`default_nettype wire

/* acc_compare.sv */
`default_nettype none

// accumulator compare.
// forms acc - dst over the selected width and derives the six status flags.
module acc_compare import cmpxchg_pkg::*; (
    input  wire logic [data_width-1:0] acc,
    input  wire logic [data_width-1:0] dst,
    input  wire size_e                 size,
    output logic      [num_flags-1:0]  flags_cmp
);

    // operands with the bits above the selected width cleared.
    logic [data_width-1:0] acc_m;
    logic [data_width-1:0] dst_m;
    logic [data_width-1:0] mask;

    // one extra bit on top catches the borrow of a full-width subtraction.
    logic [data_width:0] diff;

    // low nibble difference, bit 4 is the auxiliary borrow.
    logic [4:0] nib_diff;

    // sign bits and borrow taken at the top of the selected width.
    logic acc_sign;
    logic dst_sign;
    logic diff_sign;
    logic borrow;

    // width mask from the size code.
    always_comb begin
        case (size)
            size_8:  mask = 32'h0000_00ff;
            size_16: mask = 32'h0000_ffff;
            default: mask = 32'hffff_ffff;
        endcase
    end

    assign acc_m = acc & mask;
    assign dst_m = dst & mask;

    // upper bits are zero, so a borrow shows up just above the top bit.
    assign diff     = {1'b0, acc_m} - {1'b0, dst_m};
    assign nib_diff = {1'b0, acc[3:0]} - {1'b0, dst[3:0]};

    // pick the sign and borrow positions for the selected width.
    always_comb begin
        case (size)
            size_8: begin
                acc_sign  = acc[7];
                dst_sign  = dst[7];
                diff_sign = diff[7];
                borrow    = diff[8];
            end
            size_16: begin
                acc_sign  = acc[15];
                dst_sign  = dst[15];
                diff_sign = diff[15];
                borrow    = diff[16];
            end
            default: begin
                acc_sign  = acc[31];
                dst_sign  = dst[31];
                diff_sign = diff[31];
                borrow    = diff[32];
            end
        endcase
    end

    // flag assembly.
    always_comb begin
        flags_cmp          = '0;
        flags_cmp[flag_cf] = borrow;
        // parity looks at the low byte only, set when even.
        flags_cmp[flag_pf] = ~^diff[7:0];
        flags_cmp[flag_af] = nib_diff[4];
        flags_cmp[flag_zf] = (acc_m == dst_m);
        flags_cmp[flag_sf] = diff_sign;
        // overflow: operand signs differ and the result takes the sign of dst.
        flags_cmp[flag_of] = (acc_sign != dst_sign) && (diff_sign != acc_sign);
    end

endmodule

`default_nettype wire

/* cmpxchg_unit.sv */
`default_nettype none

// exchange datapath.
// decides what is written where and merges narrow results into the old value.
module cmpxchg_unit import cmpxchg_pkg::*; #(
    parameter int num_regs = 8
) (
    input  wire op_e                           op,
    input  wire size_e                         size,
    input  wire logic [data_width-1:0]         src_data,
    input  wire logic [data_width-1:0]         dst_data,
    input  wire logic [data_width-1:0]         acc_data,
    input  wire logic [data_width-1:0]         imm,
    input  wire logic [$clog2(num_regs)-1:0]   dst_idx,
    output logic                               wr_en,
    output logic      [$clog2(num_regs)-1:0]   wr_idx,
    output logic      [data_width-1:0]         wr_data,
    output logic      [num_flags-1:0]          flags_new,
    output logic                               flags_upd
);

    // flags of acc - dst at the selected width.
    logic [num_flags-1:0] flags_cmp;

    // replace the low byte, the low half-word or the whole word.
    // the bits above the selected width come from the old value.
    function automatic logic [data_width-1:0] merge(
        input logic [data_width-1:0] old_val,
        input logic [data_width-1:0] new_val,
        input size_e                 sz
    );
        case (sz)
            size_8:  merge = {old_val[data_width-1:8], new_val[7:0]};
            size_16: merge = {old_val[data_width-1:16], new_val[15:0]};
            default: merge = new_val;
        endcase
    endfunction

    acc_compare i_acc_compare (
        .acc       (acc_data),
        .dst       (dst_data),
        .size      (size),
        .flags_cmp (flags_cmp)
    );

    // the flags are always offered; flags_upd says whether they are taken.
    assign flags_new = flags_cmp;

    always_comb begin
        wr_en     = 1'b0;
        wr_idx    = dst_idx;
        wr_data   = merge(dst_data, src_data, size);
        flags_upd = 1'b0;
        case (op)
            op_cmpxchg: begin
                wr_en     = 1'b1;
                flags_upd = 1'b1;
                if (flags_cmp[flag_zf]) begin
                    // equal: source goes to the destination.
                    wr_idx  = dst_idx;
                    wr_data = merge(dst_data, src_data, size);
                end else begin
                    // not equal: destination is loaded into the accumulator.
                    wr_idx  = '0;
                    wr_data = merge(acc_data, dst_data, size);
                end
            end
            op_cmp: begin
                // flags only.
                flags_upd = 1'b1;
            end
            op_mov: begin
                wr_en   = 1'b1;
                wr_data = merge(dst_data, src_data, size);
            end
            op_load_imm: begin
                wr_en   = 1'b1;
                wr_data = merge(dst_data, imm, size);
            end
            default: begin
                // nop leaves registers and flags alone.
                wr_en = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* gpr_file.sv */
`default_nettype none

// general register bank.
// two operand reads, the accumulator, a debug read and one write port.
module gpr_file import cmpxchg_pkg::*; #(
    parameter int num_regs = 8
) (
    input  wire logic                          clk,
    input  wire logic                          arst_n,
    input  wire logic [$clog2(num_regs)-1:0]   src_idx,
    input  wire logic [$clog2(num_regs)-1:0]   dst_idx,
    output logic      [data_width-1:0]         src_data,
    output logic      [data_width-1:0]         dst_data,
    output logic      [data_width-1:0]         acc_data,
    input  wire logic                          wr_en,
    input  wire logic [$clog2(num_regs)-1:0]   wr_idx,
    input  wire logic [data_width-1:0]         wr_data,
    input  wire logic [$clog2(num_regs)-1:0]   dbg_idx,
    output logic      [data_width-1:0]         dbg_data
);

    logic [data_width-1:0] regs [num_regs];

    // the bank comes out of reset all zero.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (int'(wr_idx) < num_regs)) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // combinational reads.
    // an index past the last register reads as zero when num_regs is not
    // a power of two.
    assign src_data = (int'(src_idx) < num_regs) ? regs[src_idx] : '0;
    assign dst_data = (int'(dst_idx) < num_regs) ? regs[dst_idx] : '0;

    // register 0 is the accumulator.
    assign acc_data = regs[0];

    // the debug port is live at all times.
    assign dbg_data = (int'(dbg_idx) < num_regs) ? regs[dbg_idx] : '0;

endmodule

`default_nettype wire

/* exec_ctrl.sv */
`default_nettype none

// operation sequencer.
// latches a request, runs it for one cycle, then reports done.
module exec_ctrl import cmpxchg_pkg::*; #(
    parameter int num_regs = 8
) (
    input  wire logic                          clk,
    input  wire logic                          arst_n,
    input  wire logic                          start,
    input  wire op_e                           op,
    input  wire size_e                         size,
    input  wire logic [$clog2(num_regs)-1:0]   dst_idx,
    input  wire logic [$clog2(num_regs)-1:0]   src_idx,
    input  wire logic [data_width-1:0]         imm,
    output logic                               busy,
    output logic                               done,
    output op_e                                l_op,
    output size_e                              l_size,
    output logic      [$clog2(num_regs)-1:0]   l_dst_idx,
    output logic      [$clog2(num_regs)-1:0]   l_src_idx,
    output logic      [data_width-1:0]         l_imm,
    input  wire logic                          unit_wr_en,
    output logic                               gpr_wr_en,
    input  wire logic [num_flags-1:0]          flags_new,
    input  wire logic                          flags_upd,
    output logic      [num_flags-1:0]          flags
);

    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_exec = 2'd1,
        st_done = 2'd2
    } state_e;

    state_e state;
    state_e state_nxt;

    // request taken this cycle.
    logic accept;

    // a start is taken in idle and in the done cycle.
    // the done cycle accepts so that operations can run back to back.
    // a start during st_exec is dropped.
    assign accept = start && (state != st_exec);

    // next state.
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (accept) begin
                    state_nxt = st_exec;
                end
            end
            st_exec: begin
                state_nxt = st_done;
            end
            st_done: begin
                state_nxt = accept ? st_exec : st_idle;
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    // state, flag register and latched opcode.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
            flags <= '0;
            l_op  <= op_nop;
        end else begin
            state <= state_nxt;
            if (accept) begin
                l_op <= op;
            end
            // flags change on the execute edge only.
            if ((state == st_exec) && flags_upd) begin
                flags <= flags_new;
            end
        end
    end

    // operand latches.
    always_ff @(posedge clk) begin
        if (accept) begin
            l_size    <= size;
            l_dst_idx <= dst_idx;
            l_src_idx <= src_idx;
            l_imm     <= imm;
        end
    end

    // register write only on the execute edge.
    assign gpr_wr_en = unit_wr_en && (state == st_exec);

    // busy covers the execute and done cycles.
    assign busy = (state != st_idle);

    // one-cycle done after the execute edge.
    assign done = (state == st_done);

endmodule

`default_nettype wire

/* cmpxchg_top.sv */
`default_nettype none

// compare-and-exchange slice.
// controller, register bank and exchange datapath.
module cmpxchg_top import cmpxchg_pkg::*; #(
    parameter int num_regs = 8
) (
    input  wire logic                          clk,
    input  wire logic                          arst_n,
    input  wire logic                          start,
    input  wire op_e                           op,
    input  wire size_e                         size,
    input  wire logic [$clog2(num_regs)-1:0]   dst_idx,
    input  wire logic [$clog2(num_regs)-1:0]   src_idx,
    input  wire logic [data_width-1:0]         imm,
    output logic                               busy,
    output logic                               done,
    output logic      [num_flags-1:0]          flags,
    input  wire logic [$clog2(num_regs)-1:0]   dbg_idx,
    output logic      [data_width-1:0]         dbg_data
);

    localparam int idx_w = $clog2(num_regs);

    // latched request.
    op_e               l_op;
    size_e             l_size;
    logic [idx_w-1:0]  l_dst_idx;
    logic [idx_w-1:0]  l_src_idx;
    logic [data_width-1:0] l_imm;

    // operands from the bank.
    logic [data_width-1:0] src_data;
    logic [data_width-1:0] dst_data;
    logic [data_width-1:0] acc_data;

    // datapath results.
    logic                  unit_wr_en;
    logic                  gpr_wr_en;
    logic [idx_w-1:0]      wr_idx;
    logic [data_width-1:0] wr_data;
    logic [num_flags-1:0]  flags_new;
    logic                  flags_upd;

    exec_ctrl #(
        .num_regs (num_regs)
    ) i_exec_ctrl (
        .clk        (clk),
        .arst_n     (arst_n),
        .start      (start),
        .op         (op),
        .size       (size),
        .dst_idx    (dst_idx),
        .src_idx    (src_idx),
        .imm        (imm),
        .busy       (busy),
        .done       (done),
        .l_op       (l_op),
        .l_size     (l_size),
        .l_dst_idx  (l_dst_idx),
        .l_src_idx  (l_src_idx),
        .l_imm      (l_imm),
        .unit_wr_en (unit_wr_en),
        .gpr_wr_en  (gpr_wr_en),
        .flags_new  (flags_new),
        .flags_upd  (flags_upd),
        .flags      (flags)
    );

    gpr_file #(
        .num_regs (num_regs)
    ) i_gpr_file (
        .clk      (clk),
        .arst_n   (arst_n),
        .src_idx  (l_src_idx),
        .dst_idx  (l_dst_idx),
        .src_data (src_data),
        .dst_data (dst_data),
        .acc_data (acc_data),
        .wr_en    (gpr_wr_en),
        .wr_idx   (wr_idx),
        .wr_data  (wr_data),
        .dbg_idx  (dbg_idx),
        .dbg_data (dbg_data)
    );

    cmpxchg_unit #(
        .num_regs (num_regs)
    ) i_cmpxchg_unit (
        .op        (l_op),
        .size      (l_size),
        .src_data  (src_data),
        .dst_data  (dst_data),
        .acc_data  (acc_data),
        .imm       (l_imm),
        .dst_idx   (l_dst_idx),
        .wr_en     (unit_wr_en),
        .wr_idx    (wr_idx),
        .wr_data   (wr_data),
        .flags_new (flags_new),
        .flags_upd (flags_upd)
    );

endmodule

`default_nettype wire

/* cmpxchg_asserts.sv */
`default_nettype none

// protocol checks on the sequencer.
module cmpxchg_asserts (
    input wire logic clk,
    input wire logic arst_n,
    input wire logic accept,
    input wire logic busy,
    input wire logic done,
    input wire logic gpr_wr_en
);

    // failed assertions, read by the testbench at the end of the run.
    int n_fail = 0;

    // done comes two edges after an accepted start.
    a_done_after_accept: assert property (
        @(posedge clk) disable iff (!arst_n) accept |=> !done ##1 done ##1 !done
    ) else begin
        $error("done did not follow the accepted start by two edges");
        n_fail++;
    end

    // done never lasts longer than one cycle.
    a_done_one_cycle: assert property (
        @(posedge clk) disable iff (!arst_n) done |=> !done
    ) else begin
        $error("done held for more than one cycle");
        n_fail++;
    end

    // a register write only in the cycle right after an accepted start.
    a_write_in_exec: assert property (
        @(posedge clk) disable iff (!arst_n) gpr_wr_en |-> $past(accept)
    ) else begin
        $error("register write outside the execute cycle");
        n_fail++;
    end

    // first edge out of reset finds the unit idle.
    a_idle_after_reset: assert property (
        @(posedge clk) $rose(arst_n) |-> !busy
    ) else begin
        $error("busy high right after reset");
        n_fail++;
    end

endmodule

bind exec_ctrl cmpxchg_asserts i_cmpxchg_asserts (
    .clk       (clk),
    .arst_n    (arst_n),
    .accept    (accept),
    .busy      (busy),
    .done      (done),
    .gpr_wr_en (gpr_wr_en)
);

`default_nettype wire

/* cmpxchg_tb.sv */
`default_nettype none

// directed testbench for the compare-and-exchange slice.
module cmpxchg_tb import cmpxchg_pkg::*; ();

    localparam int num_regs = 8;
    localparam int idx_w    = $clog2(num_regs);
    localparam int max_wait = 20;

    logic                  clk;
    logic                  arst_n;
    logic                  start;
    op_e                   op;
    size_e                 size;
    logic [idx_w-1:0]      dst_idx;
    logic [idx_w-1:0]      src_idx;
    logic [data_width-1:0] imm;
    logic                  busy;
    logic                  done;
    logic [num_flags-1:0]  flags;
    logic [idx_w-1:0]      dbg_idx;
    logic [data_width-1:0] dbg_data;

    // reference state of the bank and the flag register.
    logic [data_width-1:0] m_regs [num_regs];
    logic [num_flags-1:0]  m_flags;
    int                    errors;
    int                    checks;

    cmpxchg_top #(
        .num_regs (num_regs)
    ) i_cmpxchg_top (
        .clk      (clk),
        .arst_n   (arst_n),
        .start    (start),
        .op       (op),
        .size     (size),
        .dst_idx  (dst_idx),
        .src_idx  (src_idx),
        .imm      (imm),
        .busy     (busy),
        .done     (done),
        .flags    (flags),
        .dbg_idx  (dbg_idx),
        .dbg_data (dbg_data)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] width_mask(input size_e sz);
        case (sz)
            size_8:  return 32'h0000_00ff;
            size_16: return 32'h0000_ffff;
            default: return 32'hffff_ffff;
        endcase
    endfunction

    // flags of acc - dst worked out from unsigned and signed ranges.
    function automatic logic [num_flags-1:0] ref_flags(
        input logic [31:0] a,
        input logic [31:0] d,
        input size_e       sz
    );
        logic [31:0]          m;
        logic [31:0]          am;
        logic [31:0]          dm;
        logic [31:0]          r;
        logic [num_flags-1:0] f;
        int                   w;
        longint               sa;
        longint               sd;
        longint               sr;
        m  = width_mask(sz);
        w  = (sz == size_8) ? 8 : ((sz == size_16) ? 16 : 32);
        am = a & m;
        dm = d & m;
        r  = (am - dm) & m;
        // signed view of each operand at the selected width.
        sa = longint'(am) - (am[w-1] ? (longint'(1) << w) : 0);
        sd = longint'(dm) - (dm[w-1] ? (longint'(1) << w) : 0);
        sr = sa - sd;
        f          = '0;
        f[flag_cf] = (am < dm);
        f[flag_pf] = ~^r[7:0];
        f[flag_af] = (a[3:0] < d[3:0]);
        f[flag_zf] = (am == dm);
        f[flag_sf] = r[w-1];
        f[flag_of] = (sr < -(longint'(1) << (w - 1))) || (sr >= (longint'(1) << (w - 1)));
        return f;
    endfunction

    function automatic logic [31:0] put_low(
        input logic [31:0] old_val,
        input logic [31:0] new_val,
        input size_e       sz
    );
        return (old_val & ~width_mask(sz)) | (new_val & width_mask(sz));
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic model_op(
        input op_e              o,
        input size_e            sz,
        input logic [idx_w-1:0] d,
        input logic [idx_w-1:0] s,
        input logic [31:0]      im
    );
        case (o)
            op_cmpxchg: begin
                m_flags = ref_flags(m_regs[0], m_regs[d], sz);
                if (m_flags[flag_zf]) begin
                    m_regs[d] = put_low(m_regs[d], m_regs[s], sz);
                end else begin
                    m_regs[0] = put_low(m_regs[0], m_regs[d], sz);
                end
            end
            op_cmp:      m_flags = ref_flags(m_regs[0], m_regs[d], sz);
            op_mov:      m_regs[d] = put_low(m_regs[d], m_regs[s], sz);
            op_load_imm: m_regs[d] = put_low(m_regs[d], im, sz);
            default:     m_flags = m_flags;
        endcase
    endtask

    // walk the debug port over the whole bank.
    task automatic check_regs();
        for (int i = 0; i < num_regs; i++) begin
            @(posedge clk);
            dbg_idx <= idx_w'(i);
            @(negedge clk);
            check_val($sformatf("dbg_data[r%0d]", i), dbg_data, m_regs[i]);
        end
    endtask

    // issue one operation, wait for done, then compare against the model.
    task automatic run_op(
        input op_e              o,
        input size_e            sz,
        input logic [idx_w-1:0] d,
        input logic [idx_w-1:0] s,
        input logic [31:0]      im
    );
        int   cycles;
        logic got;
        cycles = 0;
        got    = 1'b0;
        @(posedge clk);
        start   <= 1'b1;
        op      <= o;
        size    <= sz;
        dst_idx <= d;
        src_idx <= s;
        imm     <= im;
        // start is sampled at this edge.
        @(posedge clk);
        start <= 1'b0;
        while (!got && cycles < max_wait) begin
            @(negedge clk);
            cycles++;
            // busy holds through the execute and done cycles.
            check_val("busy", busy, 1'b1);
            got = done;
        end
        assert (got) else begin
            $display("timeout at t=%0t: done never came after start", $time);
            errors++;
        end
        check_val("done latency", cycles, 2);
        @(negedge clk);
        check_val("done", done, 1'b0);
        check_val("busy", busy, 1'b0);
        model_op(o, sz, d, s, im);
        check_val("flags", flags, m_flags);
        check_regs();
    endtask

    task automatic test_reset();
        check_val("busy", busy, 1'b0);
        check_val("done", done, 1'b0);
        check_val("flags", flags, '0);
        check_regs();
    endtask

    task automatic test_load_mov();
        // full word first so the narrow writes have upper bits to keep.
        run_op(op_load_imm, size_32, 1, 0, $urandom());
        run_op(op_load_imm, size_8, 1, 0, $urandom());
        run_op(op_load_imm, size_16, 1, 0, $urandom());
        run_op(op_load_imm, size_32, 2, 0, $urandom());
        run_op(op_mov, size_8, 2, 1, '0);
        run_op(op_mov, size_16, 2, 1, '0);
        run_op(op_mov, size_32, 3, 2, '0);
    endtask

    task automatic test_xchg_equal();
        logic [31:0] v;
        logic [31:0] m;
        size_e       sz;
        for (int i = 0; i < 3; i++) begin
            sz = size_e'(i);
            m  = width_mask(sz);
            v  = $urandom();
            run_op(op_load_imm, size_32, 0, 0, v);
            // equal in the low bits only while the upper bits may differ.
            run_op(op_load_imm, size_32, 4, 0, (v & m) | ($urandom() & ~m));
            run_op(op_load_imm, size_32, 5, 0, $urandom());
            run_op(op_cmpxchg, sz, 4, 5, '0);
            check_val("flags.zf", flags[flag_zf], 1'b1);
        end
    endtask

    task automatic test_xchg_unequal();
        logic [31:0]      a;
        logic [31:0]      d;
        logic [idx_w-1:0] di;
        size_e            sz;
        for (int i = 0; i < 6; i++) begin
            sz = size_e'(i % 3);
            a  = $urandom();
            d  = $urandom();
            if (((a ^ d) & width_mask(sz)) == 0) begin
                d = d ^ 32'h1;
            end
            // the accumulator itself would always compare equal.
            di = idx_w'(1 + ($urandom() % (num_regs - 1)));
            run_op(op_load_imm, size_32, 0, 0, a);
            run_op(op_load_imm, size_32, di, 0, d);
            run_op(op_cmpxchg, sz, di, idx_w'($urandom() % num_regs), '0);
            check_val("flags.zf", flags[flag_zf], 1'b0);
        end
    endtask

    task automatic test_cmp_only();
        for (int i = 0; i < 4; i++) begin
            run_op(op_load_imm, size_32, 0, 0, $urandom());
            run_op(op_cmp, size_e'(i % 3), idx_w'(1 + i), 0, '0);
        end
        // equal operands through the accumulator itself.
        run_op(op_cmp, size_32, 0, 0, '0);
    endtask

    // a second start lands in the execute cycle and must be dropped.
    task automatic test_start_busy();
        int n_done;
        n_done = 0;
        @(posedge clk);
        start   <= 1'b1;
        op      <= op_load_imm;
        size    <= size_32;
        dst_idx <= 6;
        imm     <= 32'h1234_5678;
        @(posedge clk);
        dst_idx <= 7;
        imm     <= 32'hdead_beef;
        @(posedge clk);
        start <= 1'b0;
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            if (done) begin
                n_done++;
            end
        end
        check_val("done count", n_done, 1);
        model_op(op_load_imm, size_32, 6, 0, 32'h1234_5678);
        check_regs();
    endtask

    initial begin
        void'($urandom(42));
        clk     = 1'b0;
        arst_n  = 1'b0;
        start   = 1'b0;
        op      = op_nop;
        size    = size_32;
        dst_idx = '0;
        src_idx = '0;
        imm     = '0;
        dbg_idx = '0;
        errors  = 0;
        checks  = 0;
        m_flags = '0;
        for (int i = 0; i < num_regs; i++) begin
            m_regs[i] = '0;
        end
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        test_reset();
        test_load_mov();
        test_xchg_equal();
        test_xchg_unequal();
        test_cmp_only();
        test_start_busy();
        // nop still takes the full two-edge path.
        run_op(op_nop, size_32, 0, 0, '0);
        // protocol assertion failures count as errors too.
        errors += i_cmpxchg_top.i_exec_ctrl.i_cmpxchg_asserts.n_fail;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
cmpxchg_pkg.sv
acc_compare.sv
cmpxchg_unit.sv
gpr_file.sv
exec_ctrl.sv
cmpxchg_top.sv
cmpxchg_asserts.sv
cmpxchg_tb.sv

/* Bender.yml */
package:
  name: cmpxchg

sources:
  - files:
      - cmpxchg_pkg.sv
      - acc_compare.sv
      - cmpxchg_unit.sv
      - gpr_file.sv
      - exec_ctrl.sv
      - cmpxchg_top.sv
  - target: test
    files:
      - cmpxchg_asserts.sv
      - cmpxchg_tb.sv
